// File: verilog/rename_params.svh
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// architectural register file size
`define ARCH_REGS 10

// physical tags, the first ARCH_REGS of them mapped at reset
`define PHY_REGS 16

// reorder buffer slots
`define ROB_DEPTH 8

// index widths
`define ARCH_WIDTH 4
`define PHY_WIDTH 4
`define ROB_WIDTH 3

`endif

// File: verilog/rename_pkg.sv
package rename_pkg;

`include "rename_params.svh"

    // architectural register index
    typedef logic [`ARCH_WIDTH-1:0] arch_reg_t;

    // physical register tag
    typedef logic [`PHY_WIDTH-1:0] phy_tag_t;

    // reorder buffer slot
    typedef logic [`ROB_WIDTH-1:0] rob_id_t;

    // lifetime of one reorder buffer entry
    typedef enum logic [1:0] {
        st_empty,
        st_waiting,
        st_done
    } rob_state_t;

endpackage

// File: verilog/rename_map.sv
`timescale 1ns/1ps

`include "rename_params.svh"

module rename_map
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      ren_valid,
    input  arch_reg_t ren_rs1,
    input  arch_reg_t ren_rs2,
    input  arch_reg_t ren_rd,
    input  phy_tag_t  free_tag,
    input  logic      free_empty,
    input  logic      rob_full,
    input  logic      flush,
    input  phy_tag_t  arch_table [`ARCH_REGS],
    output logic      ren_ready,
    output phy_tag_t  ren_rs1_phy,
    output phy_tag_t  ren_rs2_phy,
    output phy_tag_t  ren_old_phy,
    output logic      alloc
);

    // speculative map, ahead of the committed one by the in-flight renames
    phy_tag_t map_table [`ARCH_REGS];

    // free list head still named by some map entry
    logic tag_in_use;

    // source lookups see the table before this cycle's own write
    assign ren_rs1_phy = map_table[ren_rs1];
    assign ren_rs2_phy = map_table[ren_rs2];

    // previous mapping of rd, released when this instruction retires
    assign ren_old_phy = map_table[ren_rd];

    // stall on a full ROB, no free tag, or a recovery in progress
    assign ren_ready = !rob_full && !free_empty && !flush;
    assign alloc     = ren_valid && ren_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // identity map
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_table[i] <= phy_tag_t'(i);
            end
        end else if (flush) begin
            // drop every speculative mapping
            map_table <= arch_table;
        end else if (alloc) begin
            map_table[ren_rd] <= free_tag;
        end
    end

    always_comb begin
        tag_in_use = 1'b0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            if (map_table[i] == free_tag) begin
                tag_in_use = 1'b1;
            end
        end
    end

    // a granted rename must take a tag that no register maps to any more
    a_alloc_tag_free: assert property (
        @(posedge clk) disable iff (rst)
        alloc |-> !tag_in_use
    ) else $error("rename allocated tag %0d, which is still mapped", free_tag);

endmodule

// File: verilog/free_list.sv
`timescale 1ns/1ps

`include "rename_params.svh"

module free_list
    import rename_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     alloc,
    input  logic     retire_valid,
    input  phy_tag_t retire_old_phy,
    input  logic     flush,
    output phy_tag_t free_tag,
    output logic     free_empty
);

    // tag storage, indexed by the low pointer bits
    phy_tag_t fifo [`PHY_REGS];

    // pointers carry one extra wrap bit
    logic [`PHY_WIDTH:0] head;
    logic [`PHY_WIDTH:0] tail;
    logic [`PHY_WIDTH:0] commit_head;
    logic [`PHY_WIDTH:0] free_count;

    assign free_count = tail - head;
    assign free_empty = (free_count == '0);
    assign free_tag   = fifo[head[`PHY_WIDTH-1:0]];

    // pop side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
        end else if (flush) begin
            // discarded tags become the next ones handed out, same order
            head <= commit_head;
        end else if (alloc) begin
            head <= head + 1'b1;
        end
    end

    // push side and the committed view of the head
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail        <= (`PHY_WIDTH+1)'(`PHY_REGS - `ARCH_REGS);
            commit_head <= '0;
        end else if (retire_valid) begin
            tail        <= tail + 1'b1;
            commit_head <= commit_head + 1'b1;
        end
    end

    // slots 0 up to PHY_REGS-ARCH_REGS-1 start with the unmapped tags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `PHY_REGS; i++) begin
                fifo[i] <= phy_tag_t'(i + `ARCH_REGS);
            end
        end else if (retire_valid) begin
            fifo[tail[`PHY_WIDTH-1:0]] <= retire_old_phy;
        end
    end

    // with ARCH_REGS tags always held by the committed map,
    // the queue can never hold more than the remainder
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        free_count <= (`PHY_REGS - `ARCH_REGS)
    ) else $error("free list overflow, count %0d", free_count);

endmodule

// File: verilog/reorder_buffer.sv
`timescale 1ns/1ps

`include "rename_params.svh"

module reorder_buffer
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      alloc,
    input  arch_reg_t ren_rd,
    input  phy_tag_t  ren_rd_phy,
    input  phy_tag_t  ren_old_phy,
    input  logic      cmp_valid,
    input  rob_id_t   cmp_rob_id,
    input  logic      cmp_mispredict,
    output rob_id_t   alloc_id,
    output logic      rob_full,
    output logic      retire_valid,
    output arch_reg_t retire_rd,
    output phy_tag_t  retire_phy,
    output phy_tag_t  retire_old_phy,
    output logic      flush
);

    // per-entry control
    rob_state_t state [`ROB_DEPTH];
    logic       mis_q [`ROB_DEPTH];

    // per-entry payload
    arch_reg_t  rd_q  [`ROB_DEPTH];
    phy_tag_t   new_q [`ROB_DEPTH];
    phy_tag_t   old_q [`ROB_DEPTH];

    logic [`ROB_WIDTH:0] head;
    logic [`ROB_WIDTH:0] tail;
    logic [`ROB_WIDTH:0] count;
    rob_id_t             head_idx;
    rob_id_t             tail_idx;
    logic                retire_mis;

    assign head_idx = head[`ROB_WIDTH-1:0];
    assign tail_idx = tail[`ROB_WIDTH-1:0];
    assign count    = tail - head;
    assign rob_full = (count == `ROB_DEPTH);
    assign alloc_id = tail_idx;

    // head retires as soon as it is done, nothing retires while flushing
    assign retire_valid   = (state[head_idx] == st_done) && !flush;
    assign retire_rd      = rd_q[head_idx];
    assign retire_phy     = new_q[head_idx];
    assign retire_old_phy = old_q[head_idx];
    assign retire_mis     = mis_q[head_idx];

    // flush follows the retire of a mispredicted entry by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flush <= 1'b0;
        end else begin
            flush <= retire_valid && retire_mis;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else if (flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (alloc) begin
                tail <= tail + 1'b1;
            end
            if (retire_valid) begin
                head <= head + 1'b1;
            end
        end
    end

    // entry state and mispredict flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state[i] <= st_empty;
                mis_q[i] <= 1'b0;
            end
        end else if (flush) begin
            // younger entries are all wrong path
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state[i] <= st_empty;
            end
        end else begin
            if (alloc) begin
                state[tail_idx] <= st_waiting;
                mis_q[tail_idx] <= 1'b0;
            end
            if (cmp_valid) begin
                state[cmp_rob_id] <= st_done;
                mis_q[cmp_rob_id] <= cmp_mispredict;
            end
            if (retire_valid) begin
                state[head_idx] <= st_empty;
            end
        end
    end

    // payload written once at allocation
    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail_idx]  <= ren_rd;
            new_q[tail_idx] <= ren_rd_phy;
            old_q[tail_idx] <= ren_old_phy;
        end
    end

    a_cmp_waiting: assert property (
        @(posedge clk) disable iff (rst)
        cmp_valid && !flush |-> state[cmp_rob_id] == st_waiting
    ) else $error("completion for ROB id %0d, which is not waiting", cmp_rob_id);

    // the rename stage has to honour rob_full
    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (rst)
        alloc |-> !rob_full
    ) else $error("allocation into a full ROB");

endmodule

// File: verilog/arch_map.sv
`timescale 1ns/1ps

`include "rename_params.svh"

module arch_map
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      retire_valid,
    input  arch_reg_t retire_rd,
    input  phy_tag_t  retire_phy,
    output phy_tag_t  arch_table [`ARCH_REGS]
);

    // committed state only, so it doubles as the recovery image
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                arch_table[i] <= phy_tag_t'(i);
            end
        end else if (retire_valid) begin
            arch_table[retire_rd] <= retire_phy;
        end
    end

endmodule

// File: verilog/rename_core.sv
`timescale 1ns/1ps

`include "rename_params.svh"

module rename_core
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      ren_valid,
    input  arch_reg_t ren_rs1,
    input  arch_reg_t ren_rs2,
    input  arch_reg_t ren_rd,
    output logic      ren_ready,
    output phy_tag_t  ren_rs1_phy,
    output phy_tag_t  ren_rs2_phy,
    output phy_tag_t  ren_rd_phy,
    output rob_id_t   ren_rob_id,
    input  logic      cmp_valid,
    input  rob_id_t   cmp_rob_id,
    input  logic      cmp_mispredict,
    output logic      retire_valid,
    output arch_reg_t retire_rd,
    output phy_tag_t  retire_phy,
    output logic      flush
);

    logic     alloc;
    logic     free_empty;
    logic     rob_full;
    phy_tag_t ren_old_phy;
    phy_tag_t retire_old_phy;
    phy_tag_t arch_table [`ARCH_REGS];

    rename_map i_rename_map (
        .clk         (clk),
        .rst         (rst),
        .ren_valid   (ren_valid),
        .ren_rs1     (ren_rs1),
        .ren_rs2     (ren_rs2),
        .ren_rd      (ren_rd),
        .free_tag    (ren_rd_phy),
        .free_empty  (free_empty),
        .rob_full    (rob_full),
        .flush       (flush),
        .arch_table  (arch_table),
        .ren_ready   (ren_ready),
        .ren_rs1_phy (ren_rs1_phy),
        .ren_rs2_phy (ren_rs2_phy),
        .ren_old_phy (ren_old_phy),
        .alloc       (alloc)
    );

    // the free list head is the new destination tag
    free_list i_free_list (
        .clk            (clk),
        .rst            (rst),
        .alloc          (alloc),
        .retire_valid   (retire_valid),
        .retire_old_phy (retire_old_phy),
        .flush          (flush),
        .free_tag       (ren_rd_phy),
        .free_empty     (free_empty)
    );

    reorder_buffer i_reorder_buffer (
        .clk            (clk),
        .rst            (rst),
        .alloc          (alloc),
        .ren_rd         (ren_rd),
        .ren_rd_phy     (ren_rd_phy),
        .ren_old_phy    (ren_old_phy),
        .cmp_valid      (cmp_valid),
        .cmp_rob_id     (cmp_rob_id),
        .cmp_mispredict (cmp_mispredict),
        .alloc_id       (ren_rob_id),
        .rob_full       (rob_full),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_phy     (retire_phy),
        .retire_old_phy (retire_old_phy),
        .flush          (flush)
    );

    arch_map i_arch_map (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_phy   (retire_phy),
        .arch_table   (arch_table)
    );

endmodule

// File: verif/tb_rename_core.sv
`timescale 1ns/1ps

`include "rename_params.svh"

module tb_rename_core
    import rename_pkg::*;
;

    logic      clk;
    logic      rst;
    logic      ren_valid;
    arch_reg_t ren_rs1;
    arch_reg_t ren_rs2;
    arch_reg_t ren_rd;
    logic      ren_ready;
    phy_tag_t  ren_rs1_phy;
    phy_tag_t  ren_rs2_phy;
    phy_tag_t  ren_rd_phy;
    rob_id_t   ren_rob_id;
    logic      cmp_valid;
    rob_id_t   cmp_rob_id;
    logic      cmp_mispredict;
    logic      retire_valid;
    arch_reg_t retire_rd;
    phy_tag_t  retire_phy;
    logic      flush;

    integer seed = 32'hb993;
    int     errors = 0;
    int     cycles = 0;
    int     flush_count = 0;
    int     accepted;

    // reference model state
    int fmap [`ARCH_REGS];
    int amap [`ARCH_REGS];
    int free_q [$];
    int popped_q [$];
    int rob_id_q [$];
    int rob_rd_q [$];
    int rob_new_q [$];
    int rob_old_q [$];
    bit rob_done_q [$];
    bit rob_mis_q [$];
    int rob_tail;
    bit flush_m;

    rename_core i_dut (
        .clk            (clk),
        .rst            (rst),
        .ren_valid      (ren_valid),
        .ren_rs1        (ren_rs1),
        .ren_rs2        (ren_rs2),
        .ren_rd         (ren_rd),
        .ren_ready      (ren_ready),
        .ren_rs1_phy    (ren_rs1_phy),
        .ren_rs2_phy    (ren_rs2_phy),
        .ren_rd_phy     (ren_rd_phy),
        .ren_rob_id     (ren_rob_id),
        .cmp_valid      (cmp_valid),
        .cmp_rob_id     (cmp_rob_id),
        .cmp_mispredict (cmp_mispredict),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_phy     (retire_phy),
        .flush          (flush)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    // packed: ready, rs1, rs2, rd tag, rob id, retire valid, retire rd, retire tag, flush
    function automatic logic [25:0] expected_outputs(input int rs1, input int rs2);
        logic [25:0] e;
        e = '0;
        e[25]    = rob_id_q.size() < `ROB_DEPTH && free_q.size() > 0 && !flush_m;
        e[24:21] = fmap[rs1];
        e[20:17] = fmap[rs2];
        if (free_q.size() > 0) e[16:13] = free_q[0];
        e[12:10] = rob_tail % `ROB_DEPTH;
        e[9]     = rob_id_q.size() > 0 && rob_done_q[0] && !flush_m;
        if (rob_id_q.size() > 0) begin
            e[8:5] = rob_rd_q[0];
            e[4:1] = rob_new_q[0];
        end
        e[0] = flush_m;
        return e;
    endfunction

    // compare where outputs are stable
    always @(negedge clk) begin
        logic [25:0] e;
        if (!rst) begin
            e = expected_outputs(ren_rs1, ren_rs2);
            check_value("ren_ready", e[25], ren_ready);
            check_value("ren_rs1_phy", e[24:21], ren_rs1_phy);
            check_value("ren_rs2_phy", e[20:17], ren_rs2_phy);
            if (ren_valid && e[25]) begin
                check_value("ren_rd_phy", e[16:13], ren_rd_phy);
                check_value("ren_rob_id", e[12:10], ren_rob_id);
            end
            check_value("retire_valid", e[9], retire_valid);
            if (e[9]) begin
                check_value("retire_rd", e[8:5], retire_rd);
                check_value("retire_phy", e[4:1], retire_phy);
            end
            if (flush && !e[0]) begin
                $display("flush went high at %0t although no mispredicted entry retired", $time);
                errors++;
            end else begin
                check_value("flush", e[0], flush);
            end
            if (flush) flush_count++;
        end
    end

    // advance the model with the values seen at this edge
    always @(posedge clk) begin
        logic [25:0] e;
        int          k;
        int          tag;
        bit          found;
        if (!rst) begin
            e = expected_outputs(ren_rs1, ren_rs2);
            if (flush_m) begin
                fmap = amap;
                free_q = {popped_q, free_q};
                popped_q.delete();
                rob_id_q.delete();
                rob_rd_q.delete();
                rob_new_q.delete();
                rob_old_q.delete();
                rob_done_q.delete();
                rob_mis_q.delete();
                rob_tail = 0;
                flush_m = 0;
            end else begin
                if (cmp_valid) begin
                    found = 0;
                    for (k = 0; k < rob_id_q.size(); k++) begin
                        if (rob_id_q[k] == cmp_rob_id && !rob_done_q[k]) begin
                            rob_done_q[k] = 1;
                            rob_mis_q[k] = cmp_mispredict;
                            found = 1;
                        end
                    end
                    if (!found) begin
                        $display("completion at %0t names ROB id %0d, which is not in flight",
                            $time, cmp_rob_id);
                        errors++;
                    end
                end
                if (ren_valid && e[25]) begin
                    tag = free_q.pop_front();
                    popped_q.push_back(tag);
                    rob_id_q.push_back(rob_tail % `ROB_DEPTH);
                    rob_rd_q.push_back(ren_rd);
                    rob_new_q.push_back(tag);
                    rob_old_q.push_back(fmap[ren_rd]);
                    rob_done_q.push_back(0);
                    rob_mis_q.push_back(0);
                    fmap[ren_rd] = tag;
                    rob_tail++;
                end
                if (e[9]) begin
                    flush_m = rob_mis_q[0];
                    amap[rob_rd_q[0]] = rob_new_q[0];
                    void'(popped_q.pop_front());
                    free_q.push_back(rob_old_q[0]);
                    void'(rob_id_q.pop_front());
                    void'(rob_rd_q.pop_front());
                    void'(rob_new_q.pop_front());
                    void'(rob_old_q.pop_front());
                    void'(rob_done_q.pop_front());
                    void'(rob_mis_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 5000) begin
            $display("timeout, the run did not finish within 5000 cycles");
            $display("Test failures found");
            $finish;
        end
    end

    // waits for the handshake, then leaves valid low
    task automatic rename_one(input int rs1, input int rs2, input int rd);
        bit ok;
        ren_valid = 1;
        ren_rs1 = rs1;
        ren_rs2 = rs2;
        ren_rd = rd;
        do begin
            @(negedge clk);
            ok = ren_ready;
            @(posedge clk);
            #1;
        end while (!ok);
        ren_valid = 0;
    endtask

    task automatic pulse_completion(input int k, input bit mis);
        cmp_valid = 1;
        cmp_rob_id = rob_id_q[k];
        cmp_mispredict = mis;
        @(posedge clk);
        #1;
        cmp_valid = 0;
        cmp_mispredict = 0;
    endtask

    // complete everything in flight and let it retire
    task automatic drain_rob();
        int k;
        int pick;
        while (rob_id_q.size() > 0 || flush_m) begin
            pick = -1;
            for (k = rob_id_q.size() - 1; k >= 0; k--) begin
                if (!rob_done_q[k]) pick = k;
            end
            if (pick >= 0 && !flush_m) begin
                pulse_completion(pick, 0);
            end else begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic random_mix(input int n);
        int i;
        int k;
        int waiting [$];
        for (i = 0; i < n; i++) begin
            ren_valid = ({$random(seed)} % 4) != 0;
            ren_rs1 = {$random(seed)} % `ARCH_REGS;
            ren_rs2 = {$random(seed)} % `ARCH_REGS;
            ren_rd = {$random(seed)} % `ARCH_REGS;
            waiting.delete();
            for (k = 0; k < rob_id_q.size(); k++) begin
                if (!rob_done_q[k]) waiting.push_back(k);
            end
            cmp_valid = 0;
            if (!flush_m && waiting.size() > 0 && ({$random(seed)} % 2)) begin
                k = waiting[{$random(seed)} % waiting.size()];
                cmp_valid = 1;
                cmp_rob_id = rob_id_q[k];
                cmp_mispredict = ({$random(seed)} % 8) == 0;
            end
            @(posedge clk);
            #1;
        end
        ren_valid = 0;
        cmp_valid = 0;
        cmp_mispredict = 0;
    endtask

    initial begin
        int i;
        int flushes_before;
        clk = 0;
        rst = 1;
        ren_valid = 0;
        ren_rs1 = 0;
        ren_rs2 = 0;
        ren_rd = 0;
        cmp_valid = 0;
        cmp_rob_id = 0;
        cmp_mispredict = 0;
        for (i = 0; i < `ARCH_REGS; i++) begin
            fmap[i] = i;
            amap[i] = i;
        end
        for (i = `ARCH_REGS; i < `PHY_REGS; i++) free_q.push_back(i);
        rob_tail = 0;
        flush_m = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 0;

        // first rename after reset, sources still on the identity map
        ren_rs1 = 3;
        ren_rs2 = 5;
        ren_rd = 1;
        @(negedge clk);
        check_value("ren_ready", 1, ren_ready);
        check_value("retire_valid", 0, retire_valid);
        check_value("flush", 0, flush);
        check_value("ren_rs1_phy", 3, ren_rs1_phy);
        check_value("ren_rs2_phy", 5, ren_rs2_phy);
        check_value("ren_rd_phy", `ARCH_REGS, ren_rd_phy);
        check_value("ren_rob_id", 0, ren_rob_id);
        @(posedge clk);
        #1;
        rename_one(3, 5, 1);

        // dependent chain
        for (i = 0; i < 4; i++) rename_one(i % 3 + 1, i % 3, (i + 1) % 3 + 1);

        // out of order completion
        for (i = rob_id_q.size() - 1; i >= 0; i--) pulse_completion(i, 0);
        drain_rob();

        // free list runs dry after six renames
        accepted = 0;
        ren_valid = 1;
        for (i = 0; i < 9; i++) begin
            ren_rd = i % `ARCH_REGS;
            @(negedge clk);
            if (ren_ready) accepted++;
            @(posedge clk);
            #1;
        end
        ren_valid = 0;
        check_value("accepted renames", `PHY_REGS - `ARCH_REGS, accepted);
        drain_rob();

        // mispredict recovery
        flushes_before = flush_count;
        rename_one(0, 1, 2);
        rename_one(2, 2, 3);
        rename_one(3, 2, 2);
        rename_one(2, 3, 4);
        pulse_completion(1, 1);
        pulse_completion(0, 0);
        drain_rob();
        check_value("flush cycles", 1, flush_count - flushes_before);
        rename_one(2, 4, 5);
        rename_one(3, 5, 6);
        drain_rob();

        random_mix(1200);
        drain_rob();
        repeat (4) @(posedge clk);

        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/rename_map.sv
verilog/free_list.sv
verilog/reorder_buffer.sv
verilog/arch_map.sv
verilog/rename_core.sv
verif/tb_rename_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, pass or fail decided from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_rename_core \
    -Mdir obj_dir > sim.log 2>&1 && ./obj_dir/Vtb_rename_core >> sim.log 2>&1 \
    || { echo "build or simulation did not complete, see sim.log"; exit 1; }

if grep -q "Test failures found" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
